// File: source/video_gen_settings.svh
/*
 * Video generator build settings
 *   - display geometry, horizontal and vertical
 *   - sync polarity
 *   - register reset defaults
 *   - video register numbers
 */
`ifndef VIDEO_GEN_SETTINGS_SVH
`define VIDEO_GEN_SETTINGS_SVH

// horizontal geometry, offscreen pixels come before the visible pixels
`define VG_VISIBLE_WIDTH    16                  // visible pixels per line
`define VG_H_FRONT_PORCH    2                   // pixels before hsync
`define VG_H_SYNC_PULSE     3                   // hsync width in pixels
`define VG_OFFSCREEN_WIDTH  8                   // front porch + sync + back porch
`define VG_TOTAL_WIDTH      (`VG_VISIBLE_WIDTH + `VG_OFFSCREEN_WIDTH)

// vertical geometry, offscreen lines come after the visible lines
`define VG_VISIBLE_HEIGHT   6                   // visible lines per frame
`define VG_V_FRONT_PORCH    1                   // lines before vsync
`define VG_V_SYNC_PULSE     2                   // vsync width in lines
`define VG_TOTAL_HEIGHT     11                  // all lines in a frame

// active level of the sync outputs
`define VG_H_SYNC_POLARITY  0                   // hsync active low
`define VG_V_SYNC_POLARITY  1                   // vsync active high

`define VG_BORDER_RESET     8'h08               // dark grey, shows the block is alive

// video register numbers
`define VG_XR_VID_CTRL      0
`define VG_XR_VID_LEFT      1
`define VG_XR_VID_RIGHT     2
`define VG_XR_SCANLINE      3                   // read only
`define VG_XR_VID_HSIZE     4                   // read only
`define VG_XR_VID_VSIZE     5                   // read only

`endif

// File: source/video_gen_pkg.sv
/*
 * Shared types of the video generator
 *   - vector typedefs for data, colour, counters and interrupts
 *   - scan sequencer state enum
 *   - host register request and scan timing structs
 */
package video_gen_pkg;

    typedef logic [15:0] word_t;                // register data
    typedef logic [7:0]  color_t;               // colour index
    typedef logic [10:0] hres_t;                // horizontal count
    typedef logic [9:0]  vres_t;                // vertical count
    typedef logic [3:0]  reg_num_t;             // register number
    typedef logic [3:0]  intr_t;                // interrupt vector

    // order matters, the sequencers step through it by increment
    typedef enum logic [1:0] {
        SCAN_VISIBLE   = 2'b00,
        SCAN_PRE_SYNC  = 2'b01,
        SCAN_SYNC      = 2'b10,
        SCAN_POST_SYNC = 2'b11
    } scan_state_t;

    typedef struct packed {
        logic     write;                        // 1 = write, 0 = read
        reg_num_t num;
        word_t    data;                         // write data, ignored on reads
    } reg_req_t;

    typedef struct packed {
        logic  hsync;                           // next state is SYNC (horizontal)
        logic  vsync;                           // next state is SYNC (vertical)
        logic  display_ena;                     // next pixel is visible
        logic  line_visible;                    // current line is a visible line
        logic  last_visible_pixel;              // last visible pixel of the frame
        hres_t h_count;                         // registered counters
        vres_t v_count;
    } scan_timing_t;

endpackage

// File: source/video_timing.sv
/*
 * Raster scan sequencer
 *   - horizontal and vertical four-state machines with their counters
 *   - next-state decodes for sync, display enable and frame events
 */
`timescale 1ns/1ps
`include "video_gen_settings.svh"

module video_timing (
    input  logic                         clk,
    input  logic                         reset_i,
    output video_gen_pkg::scan_timing_t  timing_o
);
    import video_gen_pkg::*;

    // end-of-state counts, horizontal
    localparam hres_t H_END_VISIBLE = hres_t'(`VG_TOTAL_WIDTH - 1);
    localparam hres_t H_END_PRE     = hres_t'(`VG_H_FRONT_PORCH - 1);
    localparam hres_t H_END_SYNC    = hres_t'(`VG_H_FRONT_PORCH + `VG_H_SYNC_PULSE - 1);
    localparam hres_t H_END_POST    = hres_t'(`VG_OFFSCREEN_WIDTH - 1);

    // end-of-state counts, vertical
    localparam vres_t V_END_VISIBLE = vres_t'(`VG_VISIBLE_HEIGHT - 1);
    localparam vres_t V_END_PRE     = vres_t'(`VG_VISIBLE_HEIGHT + `VG_V_FRONT_PORCH - 1);
    localparam vres_t V_END_SYNC    =
        vres_t'(`VG_VISIBLE_HEIGHT + `VG_V_FRONT_PORCH + `VG_V_SYNC_PULSE - 1);
    localparam vres_t V_END_POST    = vres_t'(`VG_TOTAL_HEIGHT - 1);

    scan_state_t h_state;
    scan_state_t h_state_next;
    scan_state_t v_state;
    scan_state_t v_state_next;
    hres_t       h_count;
    hres_t       h_count_next;
    hres_t       h_end;                         // count where h_state advances
    vres_t       v_count;
    vres_t       v_count_next;
    vres_t       v_end;                         // count where v_state advances
    logic        h_line_last_pixel;
    logic        last_frame_pixel;

    always_comb begin
        case (h_state)
            SCAN_VISIBLE:   h_end = H_END_VISIBLE;
            SCAN_PRE_SYNC:  h_end = H_END_PRE;
            SCAN_SYNC:      h_end = H_END_SYNC;
            default:        h_end = H_END_POST;
        endcase
    end

    always_comb begin
        case (v_state)
            SCAN_VISIBLE:   v_end = V_END_VISIBLE;
            SCAN_PRE_SYNC:  v_end = V_END_PRE;
            SCAN_SYNC:      v_end = V_END_SYNC;
            default:        v_end = V_END_POST;
        endcase
    end

    assign h_state_next = (h_count == h_end) ? scan_state_t'(h_state + 2'd1) : h_state;
    assign h_line_last_pixel = (h_state == SCAN_VISIBLE) && (h_state_next == SCAN_PRE_SYNC);

    // vertical only moves on the last pixel of a line
    assign v_state_next = (h_line_last_pixel && v_count == v_end) ?
                          scan_state_t'(v_state + 2'd1) : v_state;
    assign last_frame_pixel = h_line_last_pixel && (v_state == SCAN_POST_SYNC) &&
                              (v_state_next == SCAN_VISIBLE);

    always_comb begin
        h_count_next = h_count + hres_t'(1);
        v_count_next = v_count;
        if (h_line_last_pixel) begin
            h_count_next = '0;
            v_count_next = last_frame_pixel ? '0 : v_count + vres_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= SCAN_VISIBLE;
            v_state <= SCAN_VISIBLE;
            h_count <= hres_t'(`VG_OFFSCREEN_WIDTH);   // first visible pixel
            v_count <= '0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_count_next;
            v_count <= v_count_next;
        end
    end

    assign timing_o.hsync              = (h_state_next == SCAN_SYNC);
    assign timing_o.vsync              = (v_state_next == SCAN_SYNC);
    assign timing_o.display_ena        = (h_state_next == SCAN_VISIBLE) &&
                                         (v_state_next == SCAN_VISIBLE);
    assign timing_o.line_visible       = (v_state == SCAN_VISIBLE);
    assign timing_o.last_visible_pixel = h_line_last_pixel && (v_state == SCAN_VISIBLE) &&
                                         (v_state_next == SCAN_PRE_SYNC);
    assign timing_o.h_count            = h_count;
    assign timing_o.v_count            = v_count;

endmodule

// File: source/video_regs.sv
/*
 * Video register file
 *   - four-phase req/ack host port
 *   - VID_CTRL, VID_LEFT and VID_RIGHT registers
 *   - read mux with SCANLINE, HSIZE and VSIZE status
 *   - host and vsync interrupt pulses
 */
`timescale 1ns/1ps
`include "video_gen_settings.svh"

module video_regs (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         req_i,
    input  video_gen_pkg::reg_req_t      reg_req_i,
    input  video_gen_pkg::scan_timing_t  timing_i,
    input  video_gen_pkg::intr_t         intr_status_i,
    output logic                         ack_o,
    output video_gen_pkg::word_t         rd_data_o,
    output video_gen_pkg::intr_t         intr_o,
    output video_gen_pkg::color_t        border_color_o,
    output video_gen_pkg::hres_t         vid_left_o,
    output video_gen_pkg::hres_t         vid_right_o
);
    import video_gen_pkg::*;

    localparam reg_num_t XR_VID_CTRL  = reg_num_t'(`VG_XR_VID_CTRL);
    localparam reg_num_t XR_VID_LEFT  = reg_num_t'(`VG_XR_VID_LEFT);
    localparam reg_num_t XR_VID_RIGHT = reg_num_t'(`VG_XR_VID_RIGHT);
    localparam reg_num_t XR_SCANLINE  = reg_num_t'(`VG_XR_SCANLINE);
    localparam reg_num_t XR_VID_HSIZE = reg_num_t'(`VG_XR_VID_HSIZE);
    localparam reg_num_t XR_VID_VSIZE = reg_num_t'(`VG_XR_VID_VSIZE);

    logic  access;                              // one cycle per request
    logic  wr_access;
    word_t rd_mux;

    // a request is taken only while ack is low
    assign access    = req_i && !ack_o;
    assign wr_access = access && reg_req_i.write;

    // ack follows req by one edge, both going up and coming down
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color_o <= color_t'(`VG_BORDER_RESET);
            vid_left_o     <= '0;
            vid_right_o    <= hres_t'(`VG_VISIBLE_WIDTH);  // window covers the full line
            intr_o         <= '0;
        end else begin
            intr_o <= '0;                       // pulses last one cycle
            if (wr_access) begin
                case (reg_req_i.num)
                    XR_VID_CTRL: begin
                        border_color_o <= reg_req_i.data[15:8];
                        intr_o         <= reg_req_i.data[3:0];
                    end
                    XR_VID_LEFT: begin
                        vid_left_o     <= reg_req_i.data[$bits(hres_t)-1:0];
                    end
                    XR_VID_RIGHT: begin
                        vid_right_o    <= reg_req_i.data[$bits(hres_t)-1:0];
                    end
                    default: begin
                    end
                endcase
            end
            // vsync interrupt, merged with any host pulse on bit 3
            if (timing_i.last_visible_pixel) begin
                intr_o[3] <= 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_req_i.num)
            XR_VID_CTRL:  rd_mux = {border_color_o, 4'b0, intr_status_i};
            XR_VID_LEFT:  rd_mux = word_t'(vid_left_o);
            XR_VID_RIGHT: rd_mux = word_t'(vid_right_o);
            XR_SCANLINE:  rd_mux = {~timing_i.line_visible, 15'(timing_i.v_count)};
            XR_VID_HSIZE: rd_mux = word_t'(`VG_VISIBLE_WIDTH);
            XR_VID_VSIZE: rd_mux = word_t'(`VG_VISIBLE_HEIGHT);
            default:      rd_mux = '0;
        endcase
    end

    // read data held until the next read access
    always_ff @(posedge clk) begin
        if (access && !reg_req_i.write) begin
            rd_data_o <= rd_mux;
        end
    end

endmodule

// File: source/video_out.sv
/*
 * Video output stage
 *   - registered hsync and vsync with their polarity
 *   - registered display enable
 *   - border colour outside the left/right window
 */
`timescale 1ns/1ps
`include "video_gen_settings.svh"

module video_out (
    input  logic                         clk,
    input  logic                         reset_i,
    input  video_gen_pkg::scan_timing_t  timing_i,
    input  video_gen_pkg::color_t        border_color_i,
    input  video_gen_pkg::hres_t         vid_left_i,
    input  video_gen_pkg::hres_t         vid_right_i,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         de_o,
    output video_gen_pkg::color_t        color_index_o
);
    import video_gen_pkg::*;

    localparam logic  H_POL     = 1'(`VG_H_SYNC_POLARITY);
    localparam logic  V_POL     = 1'(`VG_V_SYNC_POLARITY);
    localparam hres_t OFFSCREEN = hres_t'(`VG_OFFSCREEN_WIDTH);

    hres_t  vis_col;                            // column within the visible area
    logic   in_border;
    color_t color_next;

    assign vis_col    = timing_i.h_count - OFFSCREEN;
    assign in_border  = (vis_col < vid_left_i) || (vis_col >= vid_right_i);
    assign color_next = (timing_i.display_ena && in_border) ? border_color_i : '0;

    // all outputs change on the same edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o       <= ~H_POL;            // inactive level
            vsync_o       <= ~V_POL;
            de_o          <= 1'b0;
            color_index_o <= '0;
        end else begin
            hsync_o       <= timing_i.hsync ? H_POL : ~H_POL;
            vsync_o       <= timing_i.vsync ? V_POL : ~V_POL;
            de_o          <= timing_i.display_ena;
            color_index_o <= color_next;
        end
    end

endmodule

// File: source/video_gen.sv
/*
 * Video generator top level
 *   - scan timing, register file and output stage
 */
`timescale 1ns/1ps

module video_gen (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      req_i,            // host request, four-phase
    input  video_gen_pkg::reg_req_t   reg_req_i,
    output logic                      ack_o,
    output video_gen_pkg::word_t      rd_data_o,
    input  video_gen_pkg::intr_t      intr_status_i,    // pending interrupts, read back
    output video_gen_pkg::intr_t      intr_o,
    output logic                      hsync_o,
    output logic                      vsync_o,
    output logic                      de_o,
    output video_gen_pkg::color_t     color_index_o
);
    import video_gen_pkg::*;

    scan_timing_t timing;
    color_t       border_color;
    hres_t        vid_left;
    hres_t        vid_right;

    video_timing i_timing (
        .clk            (clk),
        .reset_i        (reset_i),
        .timing_o       (timing)
    );

    video_regs i_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_i          (req_i),
        .reg_req_i      (reg_req_i),
        .timing_i       (timing),
        .intr_status_i  (intr_status_i),
        .ack_o          (ack_o),
        .rd_data_o      (rd_data_o),
        .intr_o         (intr_o),
        .border_color_o (border_color),
        .vid_left_o     (vid_left),
        .vid_right_o    (vid_right)
    );

    video_out i_out (
        .clk            (clk),
        .reset_i        (reset_i),
        .timing_i       (timing),
        .border_color_i (border_color),
        .vid_left_i     (vid_left),
        .vid_right_i    (vid_right),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .de_o           (de_o),
        .color_index_o  (color_index_o)
    );

endmodule

// File: test/video_gen_props.sv
/*
 * Bound assertions on the video generator
 *   - hsync pulse width
 *   - ack only after a request
 *   - display enable outside hsync
 *   - single-cycle vsync interrupt
 */
`timescale 1ns/1ps
`include "video_gen_settings.svh"

module video_gen_props (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  req_i,
    input  logic                  ack_o,
    input  logic                  hsync_o,
    input  logic                  de_o,
    input  video_gen_pkg::intr_t  intr_o
);
    import video_gen_pkg::*;

    localparam logic H_POL = 1'(`VG_H_SYNC_POLARITY);

    logic hsync_active;

    assign hsync_active = (hsync_o == H_POL);

    // active for exactly the sync width before it falls
    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        $fell(hsync_active) |-> $past(hsync_active, `VG_H_SYNC_PULSE) &&
                                !$past(hsync_active, `VG_H_SYNC_PULSE + 1))
        else $error("hsync pulse width is not the sync width");

    ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(ack_o) |-> $past(req_i))
        else $error("ack_o rose without a request");

    no_de_in_hsync: assert property (@(posedge clk) disable iff (reset_i)
        !(de_o && hsync_active))
        else $error("de_o high during hsync");

    vsync_intr_pulse: assert property (@(posedge clk) disable iff (reset_i)
        intr_o[3] |=> !intr_o[3])
        else $error("intr_o bit 3 high for two cycles");

endmodule

bind video_gen video_gen_props i_props (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (req_i),
    .ack_o   (ack_o),
    .hsync_o (hsync_o),
    .de_o    (de_o),
    .intr_o  (intr_o)
);

// File: test/video_gen_tb.sv
/*
 * Testbench of the video generator
 *   - clock, reset and four-phase host requests from a seeded $random
 *   - cycle model of the scan timing, output stage and registers
 *   - per-cycle output checks and a watchdog
 */
`timescale 1ns/1ps
`include "video_gen_settings.svh"

module video_gen_tb;
    import video_gen_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int TOTAL_W         = `VG_TOTAL_WIDTH;
    localparam int FRAME_CYCLES    = `VG_TOTAL_WIDTH * `VG_TOTAL_HEIGHT;
    localparam int RUN_FRAMES      = 8;
    localparam int NUM_REQ         = 120;
    localparam int MAX_GAP         = 6;       // idle cycles between requests
    localparam int MAX_HOLD        = 3;       // extra cycles req stays high after ack
    localparam int ACK_LIMIT       = 8;       // cycles allowed for each ack edge
    localparam int REQ_CYCLES      = MAX_GAP + MAX_HOLD + 2 * ACK_LIMIT;
    localparam int SCAN_GAP        = 60;
    localparam int DIRECTED_CYCLES = 8 * (SCAN_GAP + REQ_CYCLES);
    localparam int WATCHDOG_CYCLES = 2 * RUN_FRAMES * FRAME_CYCLES +
                                     NUM_REQ * REQ_CYCLES + DIRECTED_CYCLES;

    // scan geometry as region limits
    localparam hres_t H_SYNC_START = hres_t'(`VG_H_FRONT_PORCH);
    localparam hres_t H_SYNC_END   = hres_t'(`VG_H_FRONT_PORCH + `VG_H_SYNC_PULSE);
    localparam hres_t H_OFF        = hres_t'(`VG_OFFSCREEN_WIDTH);
    localparam hres_t H_LAST       = hres_t'(`VG_TOTAL_WIDTH - 1);
    localparam vres_t V_VIS        = vres_t'(`VG_VISIBLE_HEIGHT);
    localparam vres_t V_SYNC_START = vres_t'(`VG_VISIBLE_HEIGHT + `VG_V_FRONT_PORCH);
    localparam vres_t V_SYNC_END   =
        vres_t'(`VG_VISIBLE_HEIGHT + `VG_V_FRONT_PORCH + `VG_V_SYNC_PULSE);
    localparam vres_t V_LAST       = vres_t'(`VG_TOTAL_HEIGHT - 1);
    localparam logic  H_POL        = 1'(`VG_H_SYNC_POLARITY);
    localparam logic  V_POL        = 1'(`VG_V_SYNC_POLARITY);

    localparam reg_num_t NUM_CTRL  = reg_num_t'(`VG_XR_VID_CTRL);
    localparam reg_num_t NUM_LEFT  = reg_num_t'(`VG_XR_VID_LEFT);
    localparam reg_num_t NUM_RIGHT = reg_num_t'(`VG_XR_VID_RIGHT);
    localparam reg_num_t NUM_SCAN  = reg_num_t'(`VG_XR_SCANLINE);
    localparam reg_num_t NUM_HSIZE = reg_num_t'(`VG_XR_VID_HSIZE);
    localparam reg_num_t NUM_VSIZE = reg_num_t'(`VG_XR_VID_VSIZE);

    logic     clk = 1'b0;
    logic     reset_i;
    logic     req_i;
    reg_req_t reg_req_i;
    intr_t    intr_status_i;
    logic     ack_o;
    word_t    rd_data_o;
    intr_t    intr_o;
    logic     hsync_o;
    logic     vsync_o;
    logic     de_o;
    color_t   color_index_o;

    // model state, written only by the model process
    hres_t  m_h_count;
    vres_t  m_v_count;
    color_t m_border;
    hres_t  m_left;
    hres_t  m_right;
    logic   m_ack;
    word_t  m_rd_data;
    logic   m_rd_valid;
    logic   exp_hsync;
    logic   exp_vsync;
    logic   exp_de;
    color_t exp_color;
    intr_t  exp_intr;
    logic   model_on = 1'b0;                  // set by the first reset edge
    int     frames_done = 0;

    integer seed = 32'he109;
    string  phase = "startup";

    video_gen i_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_i         (req_i),
        .reg_req_i     (reg_req_i),
        .ack_o         (ack_o),
        .rd_data_o     (rd_data_o),
        .intr_status_i (intr_status_i),
        .intr_o        (intr_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .de_o          (de_o),
        .color_index_o (color_index_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int random_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic h_in_sync(input hres_t c);
        return (c >= H_SYNC_START) && (c < H_SYNC_END);
    endfunction

    function automatic logic v_in_sync(input vres_t c);
        return (c >= V_SYNC_START) && (c < V_SYNC_END);
    endfunction

    function automatic word_t model_read(input reg_num_t num);
        word_t value;
        value = '0;
        case (num)
            NUM_CTRL:  value = {m_border, 4'b0, intr_status_i};
            NUM_LEFT:  value = word_t'(m_left);
            NUM_RIGHT: value = word_t'(m_right);
            NUM_SCAN:  value = {!(m_v_count < V_VIS), 5'b0, m_v_count};
            NUM_HSIZE: value = word_t'(`VG_VISIBLE_WIDTH);
            NUM_VSIZE: value = word_t'(`VG_VISIBLE_HEIGHT);
            default:   value = '0;
        endcase
        return value;
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %0h, actual %0h", phase, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;                                   // inputs change just after the edge
    endtask

    // one four-phase request, called just after a rising edge
    task automatic host_access(input logic write, input reg_num_t num, input word_t data,
                               output word_t rd);
        int waited;
        int hold;
        int gap;
        hold = random_below(MAX_HOLD + 1);
        gap  = random_below(MAX_GAP + 1);
        intr_status_i   = intr_t'(random_below(16));
        reg_req_i.write = write;
        reg_req_i.num   = num;
        reg_req_i.data  = data;
        req_i           = 1'b1;
        waited          = 0;
        step();
        while (!ack_o) begin
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("ERROR: ack_o did not rise after req_i went high");
                stop_run();
            end
            step();
        end
        rd = rd_data_o;
        repeat (hold) step();
        req_i  = 1'b0;
        waited = 0;
        step();
        while (ack_o) begin
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("ERROR: ack_o did not fall after req_i was released");
                stop_run();
            end
            step();
        end
        repeat (gap) step();
    endtask

    // cycle model, sees the inputs that the DUT sees at the same edge
    always @(posedge clk) begin : scan_model
        logic  line_end;
        logic  de_next;
        logic  access;
        hres_t h_next;
        vres_t v_next;
        hres_t col;
        if (reset_i) begin
            m_h_count  = H_OFF;
            m_v_count  = '0;
            m_border   = color_t'(`VG_BORDER_RESET);
            m_left     = '0;
            m_right    = hres_t'(`VG_VISIBLE_WIDTH);
            m_ack      = 1'b0;
            m_rd_valid = 1'b0;
            exp_hsync  = ~H_POL;
            exp_vsync  = ~V_POL;
            exp_de     = 1'b0;
            exp_color  = '0;
            exp_intr   = '0;
            model_on   = 1'b1;
        end else begin
            line_end = (m_h_count == H_LAST);
            h_next   = line_end ? hres_t'(0) : m_h_count + hres_t'(1);
            v_next   = m_v_count;
            if (line_end) begin
                v_next = (m_v_count == V_LAST) ? vres_t'(0) : m_v_count + vres_t'(1);
            end
            de_next   = (h_next >= H_OFF) && (v_next < V_VIS);
            col       = m_h_count - H_OFF;
            exp_hsync = h_in_sync(h_next) ? H_POL : ~H_POL;
            exp_vsync = v_in_sync(v_next) ? V_POL : ~V_POL;
            exp_de    = de_next;
            exp_color = (de_next && (col < m_left || col >= m_right)) ? m_border : '0;

            access   = req_i && !m_ack;
            exp_intr = '0;
            if (access && reg_req_i.write) begin
                if (reg_req_i.num == NUM_CTRL) begin
                    m_border = reg_req_i.data[15:8];
                    exp_intr = reg_req_i.data[3:0];
                end else if (reg_req_i.num == NUM_LEFT) begin
                    m_left = reg_req_i.data[10:0];
                end else if (reg_req_i.num == NUM_RIGHT) begin
                    m_right = reg_req_i.data[10:0];
                end
            end
            if (access && !reg_req_i.write) begin
                m_rd_data  = model_read(reg_req_i.num);
                m_rd_valid = 1'b1;
            end
            if (line_end && m_v_count == V_VIS - vres_t'(1)) begin
                exp_intr[3] = 1'b1;           // last visible pixel of the frame
            end
            if (line_end && m_v_count == V_LAST) begin
                frames_done++;
            end
            m_ack     = req_i;
            m_h_count = h_next;
            m_v_count = v_next;
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (model_on) begin
            check_value("hsync_o", 32'(exp_hsync), 32'(hsync_o));
            check_value("vsync_o", 32'(exp_vsync), 32'(vsync_o));
            check_value("de_o", 32'(exp_de), 32'(de_o));
            check_value("color_index_o", 32'(exp_color), 32'(color_index_o));
            check_value("intr_o", 32'(exp_intr), 32'(intr_o));
            check_value("ack_o", 32'(m_ack), 32'(ack_o));
            if (m_ack && m_rd_valid) begin
                check_value("rd_data_o", 32'(m_rd_data), 32'(rd_data_o));
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_run();
    end

    initial begin : main
        logic     write;
        reg_num_t num;
        word_t    data;
        word_t    rd;
        reset_i       = 1'b1;
        req_i         = 1'b0;
        reg_req_i     = '0;
        intr_status_i = '0;
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;

        phase = "reset defaults";
        host_access(1'b0, NUM_CTRL, '0, rd);
        check_value("VID_CTRL", 32'({8'h08, 4'b0, intr_status_i}), 32'(rd));
        host_access(1'b0, NUM_LEFT, '0, rd);
        check_value("VID_LEFT", 32'd0, 32'(rd));
        host_access(1'b0, NUM_RIGHT, '0, rd);
        check_value("VID_RIGHT", 32'(`VG_VISIBLE_WIDTH), 32'(rd));
        host_access(1'b0, NUM_HSIZE, '0, rd);
        check_value("VID_HSIZE", 32'(`VG_VISIBLE_WIDTH), 32'(rd));
        host_access(1'b0, NUM_VSIZE, '0, rd);
        check_value("VID_VSIZE", 32'(`VG_VISIBLE_HEIGHT), 32'(rd));

        // all four host pulses, well before the first vsync interrupt
        phase = "host interrupt";
        host_access(1'b1, NUM_CTRL, 16'h5a0f, rd);
        host_access(1'b0, NUM_CTRL, '0, rd);
        check_value("VID_CTRL", 32'({8'h5a, 4'b0, intr_status_i}), 32'(rd));

        phase = "scanline";
        repeat (6) begin
            host_access(1'b0, NUM_SCAN, '0, rd);
            repeat (random_below(SCAN_GAP)) step();
        end

        phase = "random traffic";
        for (int i = 0; i < NUM_REQ; i++) begin
            write = (random_below(2) == 1);
            num   = reg_num_t'(random_below(9));
            data  = word_t'(random_below(65536));
            if (num == NUM_LEFT || num == NUM_RIGHT) begin
                data = word_t'(random_below(TOTAL_W));
            end
            if (num == NUM_CTRL) begin
                data[3] = 1'b0;               // bit 3 is shared with the vsync interrupt
            end
            host_access(write, num, data, rd);
        end

        phase = "frames";
        while (frames_done < RUN_FRAMES) begin
            step();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: video_gen.f
+incdir+source
source/video_gen_pkg.sv
source/video_timing.sv
source/video_regs.sv
source/video_out.sv
source/video_gen.sv
test/video_gen_props.sv
test/video_gen_tb.sv

// File: Makefile
# Verilator build and run of the video generator testbench

VERILATOR ?= verilator
TOP       ?= video_gen_tb
FILELIST  ?= video_gen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

check:
	@test -f $(LOG) || (echo "no log found, use make run first"; exit 1)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
